//--- build.f
sdram_cfg_pkg.sv
sdram_cmd_pkg.sv
sdram_timer.sv
sdram_ctrl_fsm.sv
sdram_cmd_gen.sv
sdram_data_path.sv
sdram_ctrl_top.sv
sdram_mem_model_tb.sv
sdram_ctrl_tb.sv

//--- sdram_cfg_pkg.sv
`default_nettype none

package sdram_cfg_pkg;

   // Host side
   localparam int ADDR_W = 21;
   localparam int DATA_W = 16;

   // Address fields of a x16 part with 4 banks
   localparam int ROW_W  = 11;
   localparam int COL_W  = 8;
   localparam int BANK_W = 2;

   // Field positions in the host address
   localparam int ROW_START  = 8;
   localparam int COL_START  = 0;
   localparam int BANK_START = 19;

   // SDRAM address pins, A10 selects auto precharge / all banks
   localparam int SA_W      = 11;
   localparam int SA_AP_BIT = 10;

   // Mode register
   // Burst length 1, sequential, single-location write (A9 set)
   localparam int MODE_CL_START = 4;
   localparam logic [SA_W-1:0] MODE_BURST_ONE = 11'b010_0000_0000;

endpackage

`default_nettype wire

//--- sdram_cmd_gen.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_cmd_gen #(
   parameter int CAS_LATENCY = 3,
   parameter int RCD_CYCLES  = 2
) (
   input  logic                             CLK,
   input  logic                             RESET_N,
   input  logic [sdram_cfg_pkg::ADDR_W-1:0] cmd_addr,
   input  logic                             reada,
   input  logic                             writea,
   input  logic                             precharge,
   input  logic                             refresh,
   input  logic                             load_mode,
   output logic                             cm_ack,
   output logic                             dq_oe,
   output logic [sdram_cfg_pkg::SA_W-1:0]   sa,
   output logic [sdram_cfg_pkg::BANK_W-1:0] ba,
   output logic                             cs_n,
   output logic                             cke,
   output logic                             ras_n,
   output logic                             cas_n,
   output logic                             we_n
);

   import sdram_cfg_pkg::*;
   import sdram_cmd_pkg::*;

   localparam int GUARD_CYCLES   = 8;
   localparam int RECOVER_CYCLES = 4;

   localparam logic [SA_W-1:0] MODE_WORD =
      MODE_BURST_ONE | (SA_W'(CAS_LATENCY) << MODE_CL_START);
   localparam logic [SA_W-1:0] PRE_ALL_WORD = SA_W'(1) << SA_AP_BIT;

   logic                      do_rd;
   logic                      do_wr;
   logic                      do_pre;
   logic                      do_ref;
   logic                      do_lmr;
   logic                      do_act;
   logic                      do_any;
   logic                      do_rw;
   logic                      strobe_any;
   logic                      accept_ok;
   logic                      is_read;
   logic                      rw_last;
   logic [ADDR_W-1:0]         addr_q;
   logic [ROW_W-1:0]          row;
   logic [COL_W-1:0]          col;
   logic [BANK_W-1:0]         bank;
   logic [GUARD_CYCLES-1:0]   guard;
   logic [RECOVER_CYCLES-1:0] recover;
   logic [RCD_CYCLES-1:0]     rw_pipe;
   logic                      oe_state;
   logic                      oe_d;
   sdram_cmd_t                issue_cmd;
   logic                      issue_ack;
   logic [SA_W-1:0]           issue_sa;
   logic [BANK_W-1:0]         issue_ba;

   assign row  = addr_q[ROW_START +: ROW_W];
   assign col  = addr_q[COL_START +: COL_W];
   assign bank = addr_q[BANK_START +: BANK_W];

   assign do_act     = do_rd | do_wr;
   assign do_any     = do_act | do_pre | do_ref | do_lmr;
   assign do_rw      = rw_pipe[RCD_CYCLES-1];
   assign strobe_any = reada | writea | precharge | refresh | load_mode;
   assign accept_ok  = !do_any && (guard == '0) && (recover == '0);

   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         do_rd  <= 1'b0;
         do_wr  <= 1'b0;
         do_pre <= 1'b0;
         do_ref <= 1'b0;
         do_lmr <= 1'b0;
      end
      else
      begin
         do_rd  <= reada && accept_ok;
         do_wr  <= writea && accept_ok;
         do_pre <= precharge && accept_ok;
         do_ref <= refresh && accept_ok;
         do_lmr <= load_mode && accept_ok;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (accept_ok && strobe_any)
         addr_q <= cmd_addr;
   end

   // Guard window, precharge recovery, RCD delay and data bus enable
   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         guard    <= '0;
         recover  <= '0;
         rw_last  <= 1'b0;
         is_read  <= 1'b0;
         rw_pipe  <= '0;
         oe_state <= 1'b0;
         oe_d     <= 1'b0;
         dq_oe    <= 1'b0;
      end
      else
      begin
         if (do_any)
         begin
            guard   <= '1;
            rw_last <= do_act;
         end
         else
            guard <= guard >> 1;

         if (rw_last && (guard == GUARD_CYCLES'(1)))
            recover <= '1;
         else
            recover <= recover >> 1;

         if (do_act)
            is_read <= do_rd;

         rw_pipe[0] <= do_act;
         for (int i = 1; i < RCD_CYCLES; i++)
            rw_pipe[i] <= rw_pipe[i-1];

         if (do_wr)
            oe_state <= 1'b1;
         else if (do_rd || do_pre)
            oe_state <= 1'b0;
         oe_d  <= oe_state;
         dq_oe <= oe_d;
      end
   end

   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         issue_cmd <= CMD_NOP;
         issue_ack <= 1'b0;
      end
      else
      begin
         if (do_act)
            issue_cmd <= CMD_ACTIVE;
         else if (do_pre)
            issue_cmd <= CMD_PRECHARGE;
         else if (do_ref)
            issue_cmd <= CMD_REFRESH;
         else if (do_lmr)
            issue_cmd <= CMD_LOAD_MODE;
         else if (do_rw)
            issue_cmd <= is_read ? CMD_READ : CMD_WRITE;
         else
            issue_cmd <= CMD_NOP;
         issue_ack <= do_any;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (do_act)
      begin
         issue_sa <= row;
         issue_ba <= bank;
      end
      else if (do_pre)
         issue_sa <= PRE_ALL_WORD;
      else if (do_lmr)
      begin
         issue_sa <= MODE_WORD;
         issue_ba <= '0;
      end
      else if (do_rw)
      begin
         // A10 stays low so the row remains open for the explicit precharge
         issue_sa <= {{(SA_W-COL_W){1'b0}}, col};
         issue_ba <= bank;
      end
      else if (do_ref)
         issue_sa <= '0;
   end

   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         cke    <= 1'b0;
         cs_n   <= 1'b1;
         ras_n  <= 1'b1;
         cas_n  <= 1'b1;
         we_n   <= 1'b1;
         sa     <= '0;
         ba     <= '0;
         cm_ack <= 1'b0;
      end
      else
      begin
         cke                   <= 1'b1;
         cs_n                  <= 1'b0;
         {ras_n, cas_n, we_n}  <= issue_cmd;
         sa                    <= issue_sa;
         ba                    <= issue_ba;
         cm_ack                <= issue_ack;
      end
   end

   // Nothing else may start between ACTIVE and its READ/WRITE
   a_quiet_rcd: assert property (@(posedge CLK) disable iff (!RESET_N)
      (|rw_pipe) |-> !do_any);

endmodule

`default_nettype wire

//--- sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } host_op_t;

   typedef enum logic [3:0] {
      ST_INIT_WAIT,
      ST_INIT_PRE,
      ST_INIT_REF1,
      ST_INIT_REF2,
      ST_INIT_MODE,
      ST_IDLE,
      ST_REFRESH,
      ST_ACCESS,
      ST_WAIT_DATA,
      ST_CLOSE,
      ST_ACK
   } ctrl_state_t;

   // Pin encoding {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_NOP       = 3'b111,
      CMD_ACTIVE    = 3'b011,
      CMD_READ      = 3'b101,
      CMD_WRITE     = 3'b100,
      CMD_PRECHARGE = 3'b010,
      CMD_REFRESH   = 3'b001,
      CMD_LOAD_MODE = 3'b000
   } sdram_cmd_t;

endpackage

`default_nettype wire

//--- sdram_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl_fsm (
   input  logic                             CLK,
   input  logic                             RESET_N,
   input  logic                             host_req,
   input  sdram_cmd_pkg::host_op_t          host_op,
   input  logic [sdram_cfg_pkg::ADDR_W-1:0] host_addr,
   output logic                             host_ack,
   input  logic                             init_done,
   input  logic                             refresh_due,
   output logic                             refresh_clear,
   output logic                             reada,
   output logic                             writea,
   output logic                             precharge,
   output logic                             refresh,
   output logic                             load_mode,
   output logic [sdram_cfg_pkg::ADDR_W-1:0] cmd_addr,
   input  logic                             cm_ack,
   input  logic                             rdata_valid
);

   import sdram_cmd_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   host_op_t    op_q;
   logic        take_req;

   assign take_req = (state == ST_IDLE) && !refresh_due && host_req;

   always_comb
   begin
      state_nxt = state;
      unique case (state)
         ST_INIT_WAIT: if (init_done) state_nxt = ST_INIT_PRE;
         ST_INIT_PRE:  if (cm_ack) state_nxt = ST_INIT_REF1;
         ST_INIT_REF1: if (cm_ack) state_nxt = ST_INIT_REF2;
         ST_INIT_REF2: if (cm_ack) state_nxt = ST_INIT_MODE;
         ST_INIT_MODE: if (cm_ack) state_nxt = ST_IDLE;
         // Refresh takes priority over a waiting host
         ST_IDLE:
         begin
            if (refresh_due)
               state_nxt = ST_REFRESH;
            else if (host_req)
               state_nxt = ST_ACCESS;
         end
         ST_REFRESH:   if (cm_ack) state_nxt = ST_IDLE;
         ST_ACCESS:
         begin
            if (cm_ack)
               state_nxt = (op_q == OP_READ) ? ST_WAIT_DATA : ST_CLOSE;
         end
         ST_WAIT_DATA: if (rdata_valid) state_nxt = ST_CLOSE;
         ST_CLOSE:     if (cm_ack) state_nxt = ST_ACK;
         // Hold the ack until the host lets go
         ST_ACK:       if (!host_req) state_nxt = ST_IDLE;
         default:      state_nxt = ST_INIT_WAIT;
      endcase
   end

   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         state <= ST_INIT_WAIT;
         op_q  <= OP_READ;
      end
      else
      begin
         state <= state_nxt;
         if (take_req)
            op_q <= host_op;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (take_req)
         cmd_addr <= host_addr;
   end

   // Strobes follow the state and so stay up until cm_ack moves it on
   assign precharge     = (state == ST_INIT_PRE) || (state == ST_CLOSE);
   assign refresh       = (state == ST_INIT_REF1) || (state == ST_INIT_REF2) ||
                          (state == ST_REFRESH);
   assign load_mode     = (state == ST_INIT_MODE);
   assign reada         = (state == ST_ACCESS) && (op_q == OP_READ);
   assign writea        = (state == ST_ACCESS) && (op_q == OP_WRITE);
   assign host_ack      = (state == ST_ACK);
   assign refresh_clear = (state == ST_IDLE) && refresh_due;

   a_one_strobe: assert property (@(posedge CLK) disable iff (!RESET_N)
      $onehot0({reada, writea, precharge, refresh, load_mode}));

   a_ack_needs_req: assert property (@(posedge CLK) disable iff (!RESET_N)
      $rose(host_ack) |-> host_req);

endmodule

`default_nettype wire

//--- sdram_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl_tb;

   import sdram_cfg_pkg::*;
   import sdram_cmd_pkg::*;

   localparam int INIT_CYCLES    = 200;
   localparam int REFRESH_CYCLES = 400;
   localparam int CAS_LATENCY    = 3;
   localparam int RCD_CYCLES     = 2;
   localparam int CLK_PERIOD     = 8;
   localparam int RESET_CYCLES   = 10;
   localparam int NUM_TXN        = 300;
   localparam int POOL_SIZE      = 16;
   localparam int TIMEOUT_CYCLES = NUM_TXN * 40 + INIT_CYCLES + 1000;

   logic              CLK;
   logic              RESET_N;
   logic              host_req;
   host_op_t          host_op;
   logic [ADDR_W-1:0] host_addr;
   logic [DATA_W-1:0] host_wdata;
   logic              host_ack;
   logic [DATA_W-1:0] host_rdata;
   logic [SA_W-1:0]   sa;
   logic [BANK_W-1:0] ba;
   logic              cs_n;
   logic              cke;
   logic              ras_n;
   logic              cas_n;
   logic              we_n;
   logic [DATA_W-1:0] dq_out;
   logic              dq_oe;
   logic [DATA_W-1:0] dq_in;
   logic [ADDR_W-1:0] acc_addr;
   logic              init_seen;
   int                periodic_refs;
   logic              proto_error;

   logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
   logic [ADDR_W-1:0] addr_pool [POOL_SIZE];
   integer            seed;
   int                cycles;
   logic              ack_prev;
   logic              req_prev;
   logic              acked;
   int                drop_wait;

   sdram_ctrl_top #(
      .INIT_CYCLES    (INIT_CYCLES),
      .REFRESH_CYCLES (REFRESH_CYCLES),
      .CAS_LATENCY    (CAS_LATENCY),
      .RCD_CYCLES     (RCD_CYCLES)
   ) dut0 (
      .CLK        (CLK),
      .RESET_N    (RESET_N),
      .host_req   (host_req),
      .host_op    (host_op),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .host_rdata (host_rdata),
      .sa         (sa),
      .ba         (ba),
      .cs_n       (cs_n),
      .cke        (cke),
      .ras_n      (ras_n),
      .cas_n      (cas_n),
      .we_n       (we_n),
      .dq_out     (dq_out),
      .dq_oe      (dq_oe),
      .dq_in      (dq_in)
   );

   sdram_mem_model_tb #(
      .CAS_LATENCY    (CAS_LATENCY),
      .RCD_CYCLES     (RCD_CYCLES),
      .REFRESH_CYCLES (REFRESH_CYCLES)
   ) mem0 (
      .CLK           (CLK),
      .RESET_N       (RESET_N),
      .cke           (cke),
      .cs_n          (cs_n),
      .ras_n         (ras_n),
      .cas_n         (cas_n),
      .we_n          (we_n),
      .sa            (sa),
      .ba            (ba),
      .dq_out        (dq_out),
      .dq_oe         (dq_oe),
      .dq_in         (dq_in),
      .acc_addr      (acc_addr),
      .init_seen     (init_seen),
      .periodic_refs (periodic_refs),
      .proto_error   (proto_error)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   // One four-phase handshake; read data and mapping checked at the ack
   task automatic run_transaction(input host_op_t op, input logic [ADDR_W-1:0] addr,
                                  input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0] expected;
      expected = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      @(posedge CLK);
      #1;
      host_req   = 1'b1;
      host_op    = op;
      host_addr  = addr;
      host_wdata = wdata;
      @(posedge CLK);
      while (!host_ack)
         @(posedge CLK);
      assert (acc_addr == addr)
      else stop_on_error($sformatf("[ERROR] acc_addr = %h, expected %h", acc_addr, addr));
      if (op == OP_READ)
      begin
         assert (host_rdata == expected)
         else stop_on_error($sformatf("[ERROR] host_rdata = %h, expected %h",
                                      host_rdata, expected));
      end
      else
         ref_mem[addr] = wdata;
      #1;
      host_req = 1'b0;
      @(posedge CLK);
      while (host_ack)
         @(posedge CLK);
   endtask

   always @(posedge CLK)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         stop_on_error("Timeout: the host transactions did not finish in time");
      // Quiet pins and no ack until the power-up wait is over
      if (cycles <= RESET_CYCLES + INIT_CYCLES)
         assert ((!cke || cs_n || ({ras_n, cas_n, we_n} == CMD_NOP)) && !host_ack)
         else stop_on_error("Command or host_ack seen during the power-up wait");
      if (RESET_N)
      begin
         if (host_ack && !ack_prev)
         begin
            assert (host_req) else stop_on_error("host_ack rose without host_req");
            assert (!acked) else stop_on_error("Second host_ack without a new request");
            acked = 1'b1;
         end
         // A new request opens the way for the next ack
         if (host_req && !req_prev)
            acked = 1'b0;
         if (ack_prev && !host_ack)
            assert (!req_prev) else stop_on_error("host_ack fell while host_req was high");
         if (host_ack && !host_req)
         begin
            drop_wait = drop_wait + 1;
            assert (drop_wait <= 2)
            else stop_on_error("host_ack stayed high 2 cycles after host_req fell");
         end
         else
            drop_wait = 0;
         ack_prev = host_ack;
         req_prev = host_req;
      end
   end

   always @(negedge CLK)
      assert (proto_error !== 1'b1)
      else stop_on_error("SDRAM model flagged a protocol violation");

   initial
   begin
      host_op_t          op;
      logic [DATA_W-1:0] wdata;
      int                idx;
      int                gap;
      logic              end_ok;
      seed       = 32'hab892ed6;
      CLK        = 1'b0;
      RESET_N    = 1'b0;
      host_req   = 1'b0;
      host_op    = OP_READ;
      host_addr  = '0;
      host_wdata = '0;
      cycles     = 0;
      ack_prev   = 1'b0;
      req_prev   = 1'b0;
      acked      = 1'b0;
      drop_wait  = 0;
      for (int i = 0; i < POOL_SIZE; i++)
         addr_pool[i] = ADDR_W'($random(seed));
      repeat (RESET_CYCLES)
         @(posedge CLK);
      #1;
      RESET_N = 1'b1;

      for (int n = 0; n < NUM_TXN; n++)
      begin
         op    = ($random(seed) & 1) ? OP_WRITE : OP_READ;
         idx   = $random(seed) & (POOL_SIZE - 1);
         wdata = DATA_W'($random(seed));
         run_transaction(op, addr_pool[idx], wdata);
         gap = $random(seed) & 3;
         repeat (gap)
            @(posedge CLK);
      end

      end_ok = (init_seen === 1'b1) && (periodic_refs > 0);
      assert (end_ok) else $display("Init sequence or periodic refresh was never seen");
      if (end_ok)
      begin
         $display("Done: no errors");
         $finish;
      end
      else
         stop_on_error("Run ended with a failed end-of-test check");
   end

endmodule

`default_nettype wire

//--- sdram_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl_top #(
   parameter int INIT_CYCLES    = 25000,
   parameter int REFRESH_CYCLES = 960,
   parameter int CAS_LATENCY    = 3,
   parameter int RCD_CYCLES     = 2
) (
   input  logic                             CLK,
   input  logic                             RESET_N,
   input  logic                             host_req,
   input  sdram_cmd_pkg::host_op_t          host_op,
   input  logic [sdram_cfg_pkg::ADDR_W-1:0] host_addr,
   input  logic [sdram_cfg_pkg::DATA_W-1:0] host_wdata,
   output logic                             host_ack,
   output logic [sdram_cfg_pkg::DATA_W-1:0] host_rdata,
   output logic [sdram_cfg_pkg::SA_W-1:0]   sa,
   output logic [sdram_cfg_pkg::BANK_W-1:0] ba,
   output logic                             cs_n,
   output logic                             cke,
   output logic                             ras_n,
   output logic                             cas_n,
   output logic                             we_n,
   output logic [sdram_cfg_pkg::DATA_W-1:0] dq_out,
   output logic                             dq_oe,
   input  logic [sdram_cfg_pkg::DATA_W-1:0] dq_in
);

   import sdram_cfg_pkg::*;

   logic              init_done;
   logic              refresh_due;
   logic              refresh_clear;
   logic              reada;
   logic              writea;
   logic              precharge;
   logic              refresh;
   logic              load_mode;
   logic              cm_ack;
   logic              rdata_valid;
   logic [ADDR_W-1:0] cmd_addr;

   sdram_timer #(
      .INIT_CYCLES    (INIT_CYCLES),
      .REFRESH_CYCLES (REFRESH_CYCLES)
   ) timer0 (
      .CLK           (CLK),
      .RESET_N       (RESET_N),
      .refresh_clear (refresh_clear),
      .init_done     (init_done),
      .refresh_due   (refresh_due)
   );

   sdram_ctrl_fsm fsm0 (
      .CLK           (CLK),
      .RESET_N       (RESET_N),
      .host_req      (host_req),
      .host_op       (host_op),
      .host_addr     (host_addr),
      .host_ack      (host_ack),
      .init_done     (init_done),
      .refresh_due   (refresh_due),
      .refresh_clear (refresh_clear),
      .reada         (reada),
      .writea        (writea),
      .precharge     (precharge),
      .refresh       (refresh),
      .load_mode     (load_mode),
      .cmd_addr      (cmd_addr),
      .cm_ack        (cm_ack),
      .rdata_valid   (rdata_valid)
   );

   sdram_cmd_gen #(
      .CAS_LATENCY (CAS_LATENCY),
      .RCD_CYCLES  (RCD_CYCLES)
   ) cmd0 (
      .CLK       (CLK),
      .RESET_N   (RESET_N),
      .cmd_addr  (cmd_addr),
      .reada     (reada),
      .writea    (writea),
      .precharge (precharge),
      .refresh   (refresh),
      .load_mode (load_mode),
      .cm_ack    (cm_ack),
      .dq_oe     (dq_oe),
      .sa        (sa),
      .ba        (ba),
      .cs_n      (cs_n),
      .cke       (cke),
      .ras_n     (ras_n),
      .cas_n     (cas_n),
      .we_n      (we_n)
   );

   sdram_data_path #(
      .CAS_LATENCY (CAS_LATENCY)
   ) data0 (
      .CLK         (CLK),
      .RESET_N     (RESET_N),
      .ras_n       (ras_n),
      .cas_n       (cas_n),
      .we_n        (we_n),
      .dq_oe       (dq_oe),
      .host_wdata  (host_wdata),
      .dq_in       (dq_in),
      .dq_out      (dq_out),
      .host_rdata  (host_rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

`default_nettype wire

//--- sdram_data_path.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_data_path #(
   parameter int CAS_LATENCY = 3
) (
   input  logic                             CLK,
   input  logic                             RESET_N,
   input  logic                             ras_n,
   input  logic                             cas_n,
   input  logic                             we_n,
   input  logic                             dq_oe,
   input  logic [sdram_cfg_pkg::DATA_W-1:0] host_wdata,
   input  logic [sdram_cfg_pkg::DATA_W-1:0] dq_in,
   output logic [sdram_cfg_pkg::DATA_W-1:0] dq_out,
   output logic [sdram_cfg_pkg::DATA_W-1:0] host_rdata,
   output logic                             rdata_valid
);

   import sdram_cmd_pkg::*;

   logic                   read_cmd;
   logic [CAS_LATENCY-1:0] rd_pipe;

   assign read_cmd = ({ras_n, cas_n, we_n} == CMD_READ);

   // Track each READ on the pins until its data is due
   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         rd_pipe     <= '0;
         rdata_valid <= 1'b0;
      end
      else
      begin
         rd_pipe[0] <= read_cmd;
         for (int i = 1; i < CAS_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i-1];
         rdata_valid <= rd_pipe[CAS_LATENCY-1];
      end
   end

   always_ff @(posedge CLK)
   begin
      dq_out <= host_wdata;
      if (rd_pipe[CAS_LATENCY-1])
         host_rdata <= dq_in;
   end

   // Bus must be released before read data comes back
   a_no_drive_on_read: assert property (@(posedge CLK) disable iff (!RESET_N)
      (|rd_pipe) |-> !dq_oe);

endmodule

`default_nettype wire

//--- sdram_mem_model_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_mem_model_tb #(
   parameter int CAS_LATENCY    = 3,
   parameter int RCD_CYCLES     = 2,
   parameter int REFRESH_CYCLES = 400
) (
   input  logic                             CLK,
   input  logic                             RESET_N,
   input  logic                             cke,
   input  logic                             cs_n,
   input  logic                             ras_n,
   input  logic                             cas_n,
   input  logic                             we_n,
   input  logic [sdram_cfg_pkg::SA_W-1:0]   sa,
   input  logic [sdram_cfg_pkg::BANK_W-1:0] ba,
   input  logic [sdram_cfg_pkg::DATA_W-1:0] dq_out,
   input  logic                             dq_oe,
   output logic [sdram_cfg_pkg::DATA_W-1:0] dq_in,
   output logic [sdram_cfg_pkg::ADDR_W-1:0] acc_addr,
   output logic                             init_seen,
   output int                               periodic_refs,
   output logic                             proto_error
);

   import sdram_cfg_pkg::*;
   import sdram_cmd_pkg::*;

   // Refresh interval plus the longest host transaction
   localparam int REFRESH_LIMIT = REFRESH_CYCLES + 60;

   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
   logic [DATA_W-1:0] rd_pipe [CAS_LATENCY];
   sdram_cmd_t        cmd;
   logic [ADDR_W-1:0] word_addr;
   logic              row_open;
   logic [ROW_W-1:0]  open_row;
   logic [BANK_W-1:0] open_bank;
   int                init_step;
   int                since_act;
   int                since_ref;

   assign cmd   = (cs_n || !cke) ? CMD_NOP : sdram_cmd_t'({ras_n, cas_n, we_n});
   assign dq_in = rd_pipe[CAS_LATENCY-1];

   // Host word address rebuilt from bank, open row and column
   always_comb
   begin
      word_addr                       = '0;
      word_addr[BANK_START +: BANK_W] = ba;
      word_addr[ROW_START +: ROW_W]   = open_row;
      word_addr[COL_START +: COL_W]   = sa[COL_W-1:0];
   end

   task automatic raise_error(input string msg);
      $display("%s", msg);
      proto_error = 1'b1;
   endtask

   always @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         for (int i = 0; i < CAS_LATENCY; i++)
            rd_pipe[i] <= '0;
         row_open      <= 1'b0;
         init_step     <= 0;
         init_seen     <= 1'b0;
         since_act     <= 0;
         since_ref     <= 0;
         periodic_refs <= 0;
         proto_error    = 1'b0;
      end
      else
      begin
         rd_pipe[0] <= '0;
         for (int i = 1; i < CAS_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i-1];
         since_act <= since_act + 1;
         since_ref <= since_ref + 1;
         if (init_step == 4)
            assert (since_ref <= REFRESH_LIMIT)
            else raise_error($sformatf("No REFRESH for %0d cycles", since_ref));

         case (cmd)
            CMD_NOP:
            begin
            end
            CMD_PRECHARGE:
            begin
               assert (sa[SA_AP_BIT]) else raise_error("PRECHARGE without A10 set");
               if (init_step == 0)
                  init_step <= 1;
               else
                  assert (init_step == 4) else raise_error("PRECHARGE out of order in init");
               row_open <= 1'b0;
            end
            CMD_REFRESH:
            begin
               assert (!row_open) else raise_error("REFRESH while a row is open");
               if ((init_step == 1) || (init_step == 2))
                  init_step <= init_step + 1;
               else
               begin
                  assert (init_step == 4) else raise_error("REFRESH out of order in init");
                  periodic_refs <= periodic_refs + 1;
               end
               since_ref <= 0;
            end
            CMD_LOAD_MODE:
            begin
               assert (init_step == 3)
               else raise_error("LOAD_MODE before PRECHARGE and two REFRESH");
               assert (sa[6:4] == 3'(CAS_LATENCY))
               else raise_error($sformatf("[ERROR] sa[6:4] = %h, expected %h",
                                          sa[6:4], 3'(CAS_LATENCY)));
               init_step <= 4;
               init_seen <= 1'b1;
            end
            CMD_ACTIVE:
            begin
               assert (init_step == 4) else raise_error("ACTIVE before init finished");
               assert (!row_open) else raise_error("ACTIVE while a row is still open");
               row_open  <= 1'b1;
               open_row  <= sa[ROW_W-1:0];
               open_bank <= ba;
               since_act <= 1;
            end
            CMD_READ, CMD_WRITE:
            begin
               assert (row_open) else raise_error("READ or WRITE with no open row");
               assert (ba == open_bank)
               else raise_error($sformatf("[ERROR] ba = %h, expected %h", ba, open_bank));
               assert (since_act >= RCD_CYCLES)
               else raise_error("READ or WRITE too soon after ACTIVE");
               assert (!sa[SA_AP_BIT]) else raise_error("READ or WRITE with auto precharge");
               acc_addr <= word_addr;
               if (cmd == CMD_WRITE)
               begin
                  assert (dq_oe) else raise_error("WRITE while the data bus is not driven");
                  mem[word_addr] = dq_out;
               end
               else
                  rd_pipe[0] <= mem.exists(word_addr) ? mem[word_addr] : '0;
            end
            default:
               raise_error($sformatf("Unknown command %b on the pins", {ras_n, cas_n, we_n}));
         endcase
      end
   end

endmodule

`default_nettype wire

//--- sdram_timer.sv
`timescale 1ns/100ps
`default_nettype none

module sdram_timer #(
   parameter int INIT_CYCLES    = 25000,
   parameter int REFRESH_CYCLES = 960
) (
   input  logic CLK,
   input  logic RESET_N,
   input  logic refresh_clear,
   output logic init_done,
   output logic refresh_due
);

   localparam int MAX_CYCLES =
      (INIT_CYCLES > REFRESH_CYCLES) ? INIT_CYCLES : REFRESH_CYCLES;
   localparam int CNT_W = $clog2(MAX_CYCLES + 1);

   localparam logic [CNT_W-1:0] INIT_LOAD    = CNT_W'(INIT_CYCLES - 1);
   localparam logic [CNT_W-1:0] REFRESH_LOAD = CNT_W'(REFRESH_CYCLES - 1);

   logic [CNT_W-1:0] count;

   // Power-up wait first, then the same counter paces refreshes
   always_ff @(posedge CLK or negedge RESET_N)
   begin
      if (!RESET_N)
      begin
         count       <= INIT_LOAD;
         init_done   <= 1'b0;
         refresh_due <= 1'b0;
      end
      else if (!init_done)
      begin
         if (count == '0)
         begin
            init_done <= 1'b1;
            count     <= REFRESH_LOAD;
         end
         else
            count <= count - 1'b1;
      end
      else if (refresh_clear)
      begin
         refresh_due <= 1'b0;
         count       <= REFRESH_LOAD;
      end
      else if (count == '0)
      begin
         refresh_due <= 1'b1;
         count       <= REFRESH_LOAD;
      end
      else
         count <= count - 1'b1;
   end

   // FSM only takes a refresh that is pending
   a_clear_when_due: assert property (@(posedge CLK) disable iff (!RESET_N)
      refresh_clear |-> refresh_due);

endmodule

`default_nettype wire
